//--- list.f
hw/tinker_pkg.sv
hw/tinker_control.sv
hw/tinker_decoder.sv
hw/tinker_regfile.sv
hw/tinker_alu.sv
hw/tinker_memory.sv
hw/tinker_pc_unit.sv
hw/tinker_core.sv
verif/tinker_core_assert.sv
verif/tinker_core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the tinker core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tinker_core_tb -f list.f -o sim_tinker > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build returned status $status"
    exit 1
fi

./obj_dir/sim_tinker +verilator+error+limit+100 > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

//--- verif/tinker_core_tb.sv
// Tinker core testbench, loads a program table and checks the writeback trace
`timescale 1ns/1ps
`default_nettype none

module tinker_core_tb;
    import tinker_pkg::*;

    localparam word_t       RESET_PC  = 64'h2000;   // 1 << 13
    localparam int unsigned MEM_BYTES = 16384;
    localparam int          MAX_ROWS  = 64;
    localparam imm_raw_t    DATA_OFS  = 12'h400;    // Data area above the program

    logic      clk;
    logic      reset;
    logic      load_en;
    word_t     load_addr;
    instr_t    load_data;
    logic      hlt;
    logic      wb_valid;
    reg_addr_t wb_addr;
    word_t     wb_data;

    // Program table, one row per instruction word
    instr_t    prog      [MAX_ROWS];
    logic      exp_write [MAX_ROWS];                // Row traces a register write
    reg_addr_t exp_rd    [MAX_ROWS];
    word_t     exp_val   [MAX_ROWS];
    int        n_rows;
    logic      table_done;

    word_t     model_regs [32];                     // Reference register file
    word_t     model_mem  [word_t];                 // Stored doublewords by address
    int        errors;

    tinker_core #(
        .RESET_PC  (RESET_PC),
        .MEM_BYTES (MEM_BYTES)
    ) DUT (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .hlt       (hlt),
        .wb_valid  (wb_valid),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                      // 10 ns period
    end

    // ------------------------------------------------------------------------
    // Table construction and reference model
    // ------------------------------------------------------------------------
    function automatic imm_raw_t random_imm();
        return imm_raw_t'($urandom);
    endfunction

    // Append one instruction, run it on the model unless it is skipped
    task automatic add_row(input opcode_t op, input reg_addr_t rd, input reg_addr_t rs,
                           input reg_addr_t rt, input imm_raw_t imm, input logic skipped);
        word_t a;
        word_t b;
        word_t d;
        word_t s;
        word_t v;
        logic  w;
        a = model_regs[rs];
        b = model_regs[rt];
        d = model_regs[rd];
        s = {{52{imm[11]}}, imm};                   // Sign extended immediate
        w = 1'b1;
        v = '0;
        case (op)
            OP_ADD:    v = a + b;
            OP_ADDI:   v = d + s;
            OP_SUB:    v = a - b;
            OP_SUBI:   v = d - s;
            OP_AND:    v = a & b;
            OP_OR:     v = a | b;
            OP_XOR:    v = a ^ b;
            OP_NOT:    v = ~a;
            OP_SHFTR:  v = a >> b[5:0];
            OP_SHFTRI: v = word_t'($signed(d) >>> imm[5:0]);
            OP_SHFTL:  v = a << b[5:0];
            OP_SHFTLI: v = d << imm[5:0];
            OP_MOV:    v = a;
            OP_MOVL:   v = {imm, d[51:0]};          // Zero extended, top 12 bits
            OP_LOAD:   v = model_mem.exists(a + s) ? model_mem[a + s] : '0;
            OP_STORE: begin
                w = 1'b0;
                if (!skipped) begin
                    model_mem[d + s] = b;
                end
            end
            default:   w = 1'b0;                    // Branches and halt
        endcase
        prog[n_rows]      = {op, rd, rs, rt, imm};
        exp_write[n_rows] = w && !skipped;
        exp_rd[n_rows]    = rd;
        exp_val[n_rows]   = v;
        if (w && !skipped) begin
            model_regs[rd] = v;
        end
        n_rows++;
    endtask

    task automatic build_program();
        add_row(OP_ADDI,   10, 0, 0, 12'd1, 1'b0);            // r10 becomes RESET_PC
        add_row(OP_SHFTLI, 10, 0, 0, 12'd13, 1'b0);
        add_row(OP_ADDI,    1, 0, 0, random_imm(), 1'b0);     // ALU sequence
        add_row(OP_ADDI,    2, 0, 0, random_imm(), 1'b0);
        add_row(OP_ADD,     3, 1, 2, 12'd0, 1'b0);
        add_row(OP_SUB,     4, 1, 2, 12'd0, 1'b0);
        add_row(OP_SUBI,    4, 0, 0, random_imm(), 1'b0);
        add_row(OP_AND,     5, 3, 4, 12'd0, 1'b0);
        add_row(OP_OR,      6, 3, 4, 12'd0, 1'b0);
        add_row(OP_XOR,     7, 5, 6, 12'd0, 1'b0);
        add_row(OP_NOT,     8, 7, 0, 12'd0, 1'b0);
        add_row(OP_SHFTR,   9, 8, 2, 12'd0, 1'b0);
        add_row(OP_SHFTRI,  8, 0, 0, random_imm(), 1'b0);
        add_row(OP_SHFTL,   9, 3, 1, 12'd0, 1'b0);
        add_row(OP_SHFTLI,  9, 0, 0, random_imm(), 1'b0);
        add_row(OP_MOV,    11, 9, 0, 12'd0, 1'b0);
        add_row(OP_MOVL,   11, 0, 0, random_imm(), 1'b0);
        add_row(OP_STORE,  10, 0, 7, DATA_OFS, 1'b0);         // No trace entry
        add_row(OP_LOAD,   12, 10, 0, DATA_OFS, 1'b0);        // Reads back r7
        add_row(OP_ADDI,   13, 0, 0, 12'd8, 1'b0);
        add_row(OP_BRR,    13, 0, 0, 12'd0, 1'b0);            // Skips one row
        add_row(OP_ADDI,   14, 0, 0, 12'd1, 1'b1);
        add_row(OP_BRGT,   13, 0, 13, 12'd0, 1'b0);           // 0 > 8 is false
        add_row(OP_ADDI,   14, 0, 0, 12'd2, 1'b0);
        add_row(OP_MOV,    15, 10, 0, 12'd0, 1'b0);
        add_row(OP_ADDI,   15, 0, 0, imm_raw_t'(4 * (n_rows + 3)), 1'b0);  // br target
        add_row(OP_BR,     15, 0, 0, 12'd0, 1'b0);
        add_row(OP_ADDI,   16, 0, 0, 12'd1, 1'b1);
        add_row(OP_ADDI,   16, 0, 0, 12'd5, 1'b0);
        add_row(OP_HALT,    0, 0, 0, 12'd0, 1'b0);
        add_row(OP_ADDI,   17, 0, 0, 12'd1, 1'b1);            // Never reached
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Program loader, ahead of fetch once past the reset window
    // ------------------------------------------------------------------------
    initial begin
        wait (table_done);
        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= RESET_PC + word_t'(INSTR_BYTES * i);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    end

    initial begin
        wait (table_done);
        repeat (n_rows * 5 * 2 + 50) @(posedge clk);
        $display("Timeout: program did not halt within %0d cycles", n_rows * 10 + 50);
        $display("Simulation failed");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Reset, trace checking and summary
    // ------------------------------------------------------------------------
    initial begin
        int   row;
        int   post_halt;
        logic halt_seen;
        reset      = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        errors     = 0;
        n_rows     = 0;
        table_done = 1'b0;
        void'($urandom(32'h402));
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        build_program();
        table_done = 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_value("hlt", word_t'(hlt), '0);
            check_value("wb_valid", word_t'(wb_valid), '0);
        end
        @(posedge clk);
        reset <= 1'b0;                              // After 5 rising edges
        @(negedge clk);
        check_value("hlt", word_t'(hlt), '0);
        check_value("wb_valid", word_t'(wb_valid), '0);
        row       = 0;
        post_halt = 0;
        halt_seen = 1'b0;
        while (post_halt < 10) begin
            @(negedge clk);
            if (wb_valid) begin
                while (row < n_rows && !exp_write[row]) begin
                    row++;
                end
                if (row < n_rows) begin
                    check_value("wb_addr", word_t'(wb_addr), word_t'(exp_rd[row]));
                    check_value("wb_data", wb_data, exp_val[row]);
                    row++;
                end else begin
                    $display("Unexpected trace entry for r%0d at %0t", wb_addr, $time);
                    errors++;
                end
            end
            if (halt_seen) begin
                check_value("hlt", word_t'(hlt), 64'd1);
                post_halt++;
            end else if (hlt) begin
                halt_seen = 1'b1;
            end
        end
        while (row < n_rows && !exp_write[row]) begin
            row++;
        end
        if (row < n_rows) begin
            $display("Trace ended early, row %0d for r%0d never written back", row, exp_rd[row]);
            errors++;
        end
        errors = errors + DUT.u_assert.fail_count;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tinker_core_assert.sv
// Tinker core bound checks on the halt level and the writeback trace strobe
`timescale 1ns/1ps
`default_nettype none

module tinker_core_assert (
    input wire logic clk,
    input wire logic reset,
    input wire logic hlt,
    input wire logic wb_valid
);
    int fail_count = 0;                             // Failed assertions so far

    // Halted core only leaves through reset
    hlt_sticky: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
        else begin
            $error("hlt fell while reset was low");
            fail_count++;
        end

    no_wb_when_halted: assert property (@(posedge clk) disable iff (reset) !(wb_valid && hlt))
        else begin
            $error("wb_valid high while halted");
            fail_count++;
        end

    // At most one writeback per instruction, never two in a row
    no_wb_back_to_back: assert property (@(posedge clk) disable iff (reset)
                                         wb_valid |=> !wb_valid)
        else begin
            $error("wb_valid high in two consecutive cycles");
            fail_count++;
        end

endmodule

bind tinker_core tinker_core_assert u_assert (
    .clk      (clk),
    .reset    (reset),
    .hlt      (hlt),
    .wb_valid (wb_valid)
);

`default_nettype wire

//--- hw/tinker_core.sv
// Tinker core top level, multi-cycle datapath wired to its control sequencer
`timescale 1ns/1ps
`default_nettype none

module tinker_core #(
    parameter tinker_pkg::word_t RESET_PC  = 64'h2000,  // First fetch address
    parameter int unsigned       MEM_BYTES = 16384      // Byte memory size
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  load_en,         // Program load strobe
    input  wire tinker_pkg::word_t     load_addr,
    input  wire tinker_pkg::instr_t    load_data,
    output logic                       hlt,
    output logic                       wb_valid,        // Register write trace
    output tinker_pkg::reg_addr_t      wb_addr,
    output tinker_pkg::word_t          wb_data
);
    import tinker_pkg::*;

    // Step strobes from the sequencer
    logic ir_write;
    logic alu_latch;
    logic mem_read;
    logic mem_write;
    logic reg_write;
    logic mem_to_reg;
    logic pc_write;

    // Decoded fields
    instr_t    instr;
    opcode_t   opcode;
    reg_addr_t rd;
    reg_addr_t src1;
    reg_addr_t src2;
    word_t     imm;

    // Datapath values
    word_t rd_value;
    word_t src1_value;
    word_t src2_value;
    word_t alu_result;              // Held from execute
    word_t mem_data;                // Held from memory step
    word_t pc;

    // ------------------------------------------------------------------------
    // Control beside the datapath it steers
    // ------------------------------------------------------------------------
    tinker_control u_control (
        .clk        (clk),
        .reset      (reset),
        .opcode     (opcode),
        .ir_write   (ir_write),
        .alu_latch  (alu_latch),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .reg_write  (reg_write),
        .mem_to_reg (mem_to_reg),
        .pc_write   (pc_write),
        .hlt        (hlt)
    );

    tinker_decoder u_decoder (
        .clk      (clk),
        .reset    (reset),
        .ir_write (ir_write),
        .instr    (instr),
        .opcode   (opcode),
        .rd       (rd),
        .src1     (src1),
        .src2     (src2),
        .imm      (imm)
    );

    tinker_regfile u_regfile (
        .clk        (clk),
        .reset      (reset),
        .write_en   (reg_write),
        .mem_to_reg (mem_to_reg),
        .mem_value  (mem_data),
        .alu_value  (alu_result),
        .rd         (rd),
        .src1       (src1),
        .src2       (src2),
        .rd_value   (rd_value),
        .src1_value (src1_value),
        .src2_value (src2_value)
    );

    tinker_alu u_alu (
        .clk        (clk),
        .reset      (reset),
        .alu_latch  (alu_latch),
        .opcode     (opcode),
        .src1_value (src1_value),
        .src2_value (src2_value),
        .imm        (imm),
        .alu_result (alu_result)
    );

    tinker_memory #(
        .MEM_BYTES (MEM_BYTES)
    ) u_memory (
        .clk        (clk),
        .opcode     (opcode),
        .pc         (pc),
        .ir_write   (ir_write),
        .read_en    (mem_read),
        .write_en   (mem_write),
        .rd_value   (rd_value),
        .src1_value (src1_value),
        .src2_value (src2_value),
        .imm        (imm),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .instr      (instr),
        .mem_data   (mem_data)
    );

    tinker_pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_pc_unit (
        .clk        (clk),
        .reset      (reset),
        .pc_write   (pc_write),
        .opcode     (opcode),
        .rd_value   (rd_value),
        .src1_value (src1_value),
        .src2_value (src2_value),
        .pc         (pc)
    );

    // Trace mirrors the register file write port
    assign wb_valid = reg_write;
    assign wb_addr  = rd;
    assign wb_data  = mem_to_reg ? mem_data : alu_result;

endmodule

`default_nettype wire

//--- hw/tinker_pc_unit.sv
// Tinker PC unit, program counter register and branch resolution
`timescale 1ns/1ps
`default_nettype none

module tinker_pc_unit #(
    parameter tinker_pkg::word_t RESET_PC = 64'h2000
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                pc_write,
    input  wire tinker_pkg::opcode_t opcode,
    input  wire tinker_pkg::word_t   rd_value,      // Branch target or offset
    input  wire tinker_pkg::word_t   src1_value,    // brgt rs
    input  wire tinker_pkg::word_t   src2_value,    // brgt rt
    output tinker_pkg::word_t        pc
);
    import tinker_pkg::*;

    word_t pc_seq;
    word_t pc_next;

    assign pc_seq = pc + word_t'(INSTR_BYTES);

    always_comb begin
        case (opcode)
            OP_BR:   pc_next = rd_value;
            OP_BRR:  pc_next = pc + rd_value;
            OP_BRGT: pc_next = ($signed(src1_value) > $signed(src2_value)) ? rd_value : pc_seq;
            default: pc_next = pc_seq;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (pc_write) begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

//--- hw/tinker_memory.sv
// Tinker byte memory with program load port, address generation and load data register
`timescale 1ns/1ps
`default_nettype none

module tinker_memory #(
    parameter int unsigned MEM_BYTES = 16384
) (
    input  wire logic                clk,
    input  wire tinker_pkg::opcode_t opcode,
    input  wire tinker_pkg::word_t   pc,
    input  wire logic                ir_write,      // Fetch selects the PC
    input  wire logic                read_en,
    input  wire logic                write_en,
    input  wire tinker_pkg::word_t   rd_value,      // Store base
    input  wire tinker_pkg::word_t   src1_value,    // Load base
    input  wire tinker_pkg::word_t   src2_value,    // Store data
    input  wire tinker_pkg::word_t   imm,
    input  wire logic                load_en,
    input  wire tinker_pkg::word_t   load_addr,
    input  wire tinker_pkg::instr_t  load_data,
    output tinker_pkg::instr_t       instr,
    output tinker_pkg::word_t        mem_data
);
    import tinker_pkg::*;

    localparam int unsigned AW = $clog2(MEM_BYTES);

    logic [7:0] mem [MEM_BYTES];
    word_t addr;
    word_t rdata;

    function automatic logic in_range(word_t a);
        return a < word_t'(MEM_BYTES);
    endfunction

    function automatic logic [AW-1:0] idx(word_t a);
        return a[AW-1:0];
    endfunction

    // ------------------------------------------------------------------------
    // Address generation
    // ------------------------------------------------------------------------
    always_comb begin
        if (ir_write) begin
            addr = pc;
        end else if (is_store(opcode)) begin
            addr = rd_value + imm;                          // rd + imm
        end else begin
            addr = src1_value + imm;                        // rs + imm
        end
    end

    // Little-endian reads, out of range bytes read zero
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            rdata[8*k +: 8] = in_range(addr + k) ? mem[idx(addr + k)] : 8'h00;
        end
    end

    assign instr = rdata[31:0];

    always_ff @(posedge clk) begin
        if (read_en) begin
            mem_data <= rdata;
        end
    end

    // ------------------------------------------------------------------------
    // Writes, store and program load
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (write_en) begin
            for (int k = 0; k < 8; k++) begin
                if (in_range(addr + k)) begin
                    mem[idx(addr + k)] <= src2_value[8*k +: 8];
                end
            end
        end
        if (load_en) begin
            for (int k = 0; k < 4; k++) begin
                if (in_range(load_addr + k)) begin
                    mem[idx(load_addr + k)] <= load_data[8*k +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/tinker_alu.sv
// Tinker ALU, operand select, integer operations and the result register
`timescale 1ns/1ps
`default_nettype none

module tinker_alu (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                alu_latch,
    input  wire tinker_pkg::opcode_t opcode,
    input  wire tinker_pkg::word_t   src1_value,
    input  wire tinker_pkg::word_t   src2_value,
    input  wire tinker_pkg::word_t   imm,
    output tinker_pkg::word_t        alu_result
);
    import tinker_pkg::*;

    word_t op2;
    word_t result;
    logic [5:0] shamt;

    assign op2   = uses_literal(opcode) ? imm : src2_value;
    assign shamt = op2[5:0];            // Shifts use low 6 bits

    always_comb begin
        case (opcode)
            OP_ADD, OP_ADDI: result = src1_value + op2;
            OP_SUB, OP_SUBI: result = src1_value - op2;
            OP_AND:          result = src1_value & op2;
            OP_OR:           result = src1_value | op2;
            OP_XOR:          result = src1_value ^ op2;
            OP_NOT:          result = ~src1_value;
            OP_SHFTR:        result = src1_value >> shamt;
            OP_SHFTRI:       result = word_t'($signed(src1_value) >>> shamt);
            OP_SHFTL:        result = src1_value << shamt;
            OP_SHFTLI:       result = src1_value << shamt;
            OP_MOV:          result = src1_value;
            OP_MOVL:         result = {op2[11:0], src1_value[51:0]};   // Top 12 bits replaced
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alu_result <= '0;
        end else if (alu_latch) begin
            alu_result <= result;
        end
    end

endmodule

`default_nettype wire

//--- hw/tinker_regfile.sv
// Tinker register file, 32 words with three read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module tinker_regfile (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  write_en,
    input  wire logic                  mem_to_reg,  // Write select
    input  wire tinker_pkg::word_t     mem_value,
    input  wire tinker_pkg::word_t     alu_value,
    input  wire tinker_pkg::reg_addr_t rd,          // Write index, also read
    input  wire tinker_pkg::reg_addr_t src1,
    input  wire tinker_pkg::reg_addr_t src2,
    output tinker_pkg::word_t          rd_value,
    output tinker_pkg::word_t          src1_value,
    output tinker_pkg::word_t          src2_value
);
    import tinker_pkg::*;

    word_t regs [32];                   // r0 is writable
    word_t write_data;

    assign write_data = mem_to_reg ? mem_value : alu_value;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[rd] <= write_data;
        end
    end

    // Asynchronous reads
    assign rd_value   = regs[rd];
    assign src1_value = regs[src1];
    assign src2_value = regs[src2];

endmodule

`default_nettype wire

//--- hw/tinker_decoder.sv
// Tinker decoder, instruction register with field and immediate extraction
`timescale 1ns/1ps
`default_nettype none

module tinker_decoder (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  ir_write,
    input  wire tinker_pkg::instr_t    instr,       // From memory fetch port
    output tinker_pkg::opcode_t        opcode,
    output tinker_pkg::reg_addr_t      rd,
    output tinker_pkg::reg_addr_t      src1,
    output tinker_pkg::reg_addr_t      src2,
    output tinker_pkg::word_t          imm          // Extended immediate
);
    import tinker_pkg::*;

    instr_t   ir;
    imm_raw_t imm_raw;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ir <= '0;
        end else if (ir_write) begin
            ir <= instr;
        end
    end

    assign opcode  = ir[OPCODE_LSB +: 5];
    assign rd      = ir[RD_LSB +: 5];
    assign src2    = ir[RT_LSB +: 5];
    assign imm_raw = ir[IMM_LSB +: 12];

    // movl merges into rd, so it reads rd too
    assign src1 = (uses_rd_as_src(opcode) || opcode == OP_MOVL) ? ir[RD_LSB +: 5]
                                                                 : ir[RS_LSB +: 5];

    // Zero extend for movl only
    assign imm = (opcode == OP_MOVL) ? {52'b0, imm_raw} : {{52{imm_raw[11]}}, imm_raw};

endmodule

`default_nettype wire

//--- hw/tinker_control.sv
// Tinker control sequencer, one state per clock, decoding the per-step strobes
`timescale 1ns/1ps
`default_nettype none

module tinker_control (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire tinker_pkg::opcode_t opcode,
    output logic                     ir_write,      // Latch instruction
    output logic                     alu_latch,     // Latch ALU result
    output logic                     mem_read,      // Latch load data
    output logic                     mem_write,     // Store to memory
    output logic                     reg_write,     // Register file write
    output logic                     mem_to_reg,    // Writeback from memory
    output logic                     pc_write,      // Advance or branch
    output logic                     hlt
);
    import tinker_pkg::*;

    state_t state;
    state_t next_state;

    // ------------------------------------------------------------------------
    // State register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_FETCH:     next_state = S_DECODE;
            S_DECODE: begin
                if (opcode == OP_HALT) begin
                    next_state = S_HALTED;                  // Parks here until reset
                end else begin
                    next_state = S_EXECUTE;
                end
            end
            S_EXECUTE: begin
                if (is_load(opcode) || is_store(opcode)) begin
                    next_state = S_MEMORY;
                end else if (is_branch(opcode)) begin
                    next_state = S_FETCH;                   // PC already resolved
                end else begin
                    next_state = S_WRITEBACK;
                end
            end
            S_MEMORY:    next_state = S_WRITEBACK;
            S_WRITEBACK: next_state = S_FETCH;
            S_HALTED:    next_state = S_HALTED;
            default:     next_state = S_FETCH;
        endcase
    end

    // ------------------------------------------------------------------------
    // Strobes per state
    // ------------------------------------------------------------------------
    always_comb begin
        ir_write   = 1'b0;
        alu_latch  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        reg_write  = 1'b0;
        mem_to_reg = 1'b0;
        pc_write   = 1'b0;
        case (state)
            S_FETCH:   ir_write = 1'b1;
            S_EXECUTE: begin
                alu_latch = 1'b1;
                pc_write  = is_branch(opcode);              // Taken or not, resolved here
            end
            S_MEMORY: begin
                mem_read  = is_load(opcode);
                mem_write = is_store(opcode);
            end
            S_WRITEBACK: begin
                reg_write  = writes_reg(opcode);
                mem_to_reg = is_load(opcode);
                pc_write   = 1'b1;                          // Sequential PC+4
            end
            default: begin
            end
        endcase
    end

    assign hlt = (state == S_HALTED);

endmodule

`default_nettype wire

//--- hw/tinker_pkg.sv
// Tinker core shared types, opcode encodings, field positions and opcode-class helpers
`default_nettype none

package tinker_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    typedef logic [63:0] word_t;                // Data and address word
    typedef logic [31:0] instr_t;               // Instruction word
    typedef logic [4:0]  reg_addr_t;            // Register index
    typedef logic [4:0]  opcode_t;              // Opcode field
    typedef logic [11:0] imm_raw_t;             // Raw immediate field

    // Sequencer states, one per clock
    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEMORY,
        S_WRITEBACK,
        S_HALTED
    } state_t;

    localparam int unsigned INSTR_BYTES = 4;    // PC step per instruction

    // Field LSBs within the instruction word
    localparam int unsigned OPCODE_LSB = 27;    // Bits 31..27
    localparam int unsigned RD_LSB     = 22;    // Bits 26..22
    localparam int unsigned RS_LSB     = 17;    // Bits 21..17
    localparam int unsigned RT_LSB     = 12;    // Bits 16..12
    localparam int unsigned IMM_LSB    = 0;     // Bits 11..0

    // ------------------------------------------------------------------------
    // Opcodes
    // ------------------------------------------------------------------------
    localparam opcode_t OP_AND    = 5'b00000;
    localparam opcode_t OP_OR     = 5'b00001;
    localparam opcode_t OP_XOR    = 5'b00010;
    localparam opcode_t OP_NOT    = 5'b00011;
    localparam opcode_t OP_SHFTR  = 5'b00100;
    localparam opcode_t OP_SHFTRI = 5'b00101;   // Arithmetic, by immediate
    localparam opcode_t OP_SHFTL  = 5'b00110;
    localparam opcode_t OP_SHFTLI = 5'b00111;
    localparam opcode_t OP_BR     = 5'b01000;   // Absolute jump to rd
    localparam opcode_t OP_BRR    = 5'b01001;   // PC-relative jump
    localparam opcode_t OP_BRGT   = 5'b01110;   // Signed rs > rt
    localparam opcode_t OP_LOAD   = 5'b10000;
    localparam opcode_t OP_MOV    = 5'b10001;
    localparam opcode_t OP_MOVL   = 5'b10010;
    localparam opcode_t OP_STORE  = 5'b10011;
    localparam opcode_t OP_ADD    = 5'b11000;
    localparam opcode_t OP_ADDI   = 5'b11001;
    localparam opcode_t OP_SUB    = 5'b11010;
    localparam opcode_t OP_SUBI   = 5'b11011;
    localparam opcode_t OP_HALT   = 5'b11111;

    // ------------------------------------------------------------------------
    // Opcode classes
    // ------------------------------------------------------------------------
    function automatic logic is_load(opcode_t op);
        return op == OP_LOAD;
    endfunction

    function automatic logic is_store(opcode_t op);
        return op == OP_STORE;
    endfunction

    function automatic logic is_branch(opcode_t op);
        return op == OP_BR || op == OP_BRR || op == OP_BRGT;
    endfunction

    // Operand 2 comes from the immediate
    function automatic logic uses_literal(opcode_t op);
        return op == OP_ADDI || op == OP_SUBI || op == OP_SHFTRI || op == OP_SHFTLI ||
               op == OP_MOVL || op == OP_LOAD || op == OP_STORE;
    endfunction

    // Two-operand immediate forms read rd as src1
    function automatic logic uses_rd_as_src(opcode_t op);
        return op == OP_ADDI || op == OP_SUBI || op == OP_SHFTRI || op == OP_SHFTLI;
    endfunction

    function automatic logic writes_reg(opcode_t op);
        return !(is_store(op) || is_branch(op) || op == OP_HALT);
    endfunction

endpackage

`default_nettype wire
